/* compile.f */
source/rs_pkg.sv
source/rs_payload_array.sv
source/rs_entry_ctrl.sv
source/rs_station.sv
verification/rs_station_tb.sv

/* Makefile */
TOP = rs_station_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* verification/rs_station_tb.sv */
/* Testbench for the reservation station, directed table then random soak
   Every cycle is checked against a reference model of the entry rules */
`timescale 1ns/1ps

module rs_station_tb;
   import rs_pkg::*;

   localparam int n_ent    = rs_num_entries;
   localparam int enc_w    = rs_enc_w;
   localparam int soak_len = 2000;

   // One directed step, stimulus plus expected outputs
   typedef struct packed {
      rs_dispatch_t d0;
      rs_dispatch_t d1;
      logic         wv;
      rs_tag_t      wt;
      logic         ir;
      logic         e_iv;
      rs_issue_t    e_is;
      logic         e_dr;
   } step_t;

   localparam rs_dispatch_t no_disp = '0;

   logic         nclk;
   logic         rst;
   rs_dispatch_t disp0;
   rs_dispatch_t disp1;
   logic         disp_ready;
   logic         wake_valid;
   rs_tag_t      wake_tag;
   logic         issue_valid;
   rs_issue_t    issue;
   logic         issue_ready;

   step_t        steps [$];
   int           err_table = 0;
   int           err_model = 0;
   logic [31:0]  rng_state = 32'he5b3_54dc;

   // Reference model state
   logic         m_valid [n_ent];
   logic         m_r0 [n_ent];
   logic         m_r1 [n_ent];
   rs_tag_t      m_t0 [n_ent];
   rs_tag_t      m_t1 [n_ent];
   rs_payload_t  m_pay [n_ent];
   logic         m_hold;
   logic [enc_w-1:0] m_hold_idx;
   logic [enc_w-1:0] m_sel;
   logic         m_exp_iv;
   logic         m_exp_dr;
   rs_issue_t    m_exp_is;

   rs_station #(
      .num_entries (n_ent)
   ) rs_station_inst (
      .nclk        (nclk),
      .rst         (rst),
      .disp0       (disp0),
      .disp1       (disp1),
      .disp_ready  (disp_ready),
      .wake_valid  (wake_valid),
      .wake_tag    (wake_tag),
      .issue_valid (issue_valid),
      .issue       (issue),
      .issue_ready (issue_ready)
   );

   initial
   begin
      nclk = 1'b0;
      forever #4 nclk = ~nclk;
   end

   // --------------------------------------------------
   // Stimulus helpers
   // --------------------------------------------------

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Payload fields all follow from one opcode number
   function automatic rs_payload_t pay_of(input int op);
      rs_payload_t p;
      p.opcode = 6'(op);
      p.dst    = 5'(op + 20);
      p.imm    = 16'(op * 257 + 16'h4000);
      return p;
   endfunction

   function automatic rs_dispatch_t disp_of(input int op, input int t0, input int r0,
                                            input int t1, input int r1);
      rs_dispatch_t d;
      d.valid      = 1'b1;
      d.payload    = pay_of(op);
      d.src0.tag   = rs_tag_t'(t0);
      d.src0.ready = 1'(r0);
      d.src1.tag   = rs_tag_t'(t1);
      d.src1.ready = 1'(r1);
      return d;
   endfunction

   function automatic rs_issue_t issue_of(input int op, input int t0, input int t1);
      rs_issue_t is;
      is.payload  = pay_of(op);
      is.src0_tag = rs_tag_t'(t0);
      is.src1_tag = rs_tag_t'(t1);
      return is;
   endfunction

   // Small tag range so random wakeups hit often
   function automatic rs_dispatch_t rand_disp(input logic [31:0] a, input logic [31:0] b);
      rs_dispatch_t d;
      d.valid      = a[0];
      d.payload    = a[27:1];
      d.src0.tag   = {2'b00, b[2:0]};
      d.src0.ready = b[3];
      d.src1.tag   = {2'b00, b[6:4]};
      d.src1.ready = b[7];
      return d;
   endfunction

   task automatic add_step(input rs_dispatch_t d0, input rs_dispatch_t d1, input int wv,
                           input int wt, input int ir, input int e_iv, input rs_issue_t e_is,
                           input int e_dr);
      step_t s;
      s.d0   = d0;
      s.d1   = d1;
      s.wv   = 1'(wv);
      s.wt   = rs_tag_t'(wt);
      s.ir   = 1'(ir);
      s.e_iv = 1'(e_iv);
      s.e_is = e_is;
      s.e_dr = 1'(e_dr);
      steps.push_back(s);
   endtask

   // --------------------------------------------------
   // Directed table
   // --------------------------------------------------
   // Columns: lane 0, lane 1, wake valid, wake tag, issue_ready,
   // then expected issue_valid, issue and disp_ready before the edge
   task automatic build_table();
      add_step(no_disp, no_disp, 0, 0, 1, 0, '0, 1);
      // Both sources ready, issues next cycle
      add_step(disp_of(1, 2, 1, 3, 1), no_disp, 0, 0, 1, 0, '0, 1);
      add_step(no_disp, no_disp, 0, 0, 1, 1, issue_of(1, 2, 3), 1);
      // Waits for tag 4, tag 6 must not release it
      add_step(disp_of(2, 4, 0, 5, 1), no_disp, 0, 0, 1, 0, '0, 1);
      add_step(no_disp, no_disp, 1, 6, 1, 0, '0, 1);
      add_step(no_disp, no_disp, 1, 4, 1, 0, '0, 1);
      add_step(no_disp, no_disp, 0, 0, 1, 1, issue_of(2, 4, 5), 1);
      // Bypass on lane 0, both lanes to entries 0 and 1
      add_step(disp_of(3, 7, 0, 8, 1), disp_of(4, 1, 1, 1, 1), 1, 7, 1, 0, '0, 1);
      add_step(no_disp, no_disp, 0, 0, 1, 1, issue_of(3, 7, 8), 1);
      add_step(no_disp, no_disp, 0, 0, 1, 1, issue_of(4, 1, 1), 1);
      // Fill under back-pressure, held pick ignores entry 0 waking
      add_step(disp_of(5, 10, 0, 11, 1), disp_of(6, 1, 1, 1, 1), 0, 0, 0, 0, '0, 1);
      add_step(disp_of(7, 1, 1, 1, 1), disp_of(8, 12, 0, 12, 0), 0, 0, 0,
               1, issue_of(6, 1, 1), 1);
      add_step(disp_of(9, 13, 0, 13, 0), disp_of(10, 14, 0, 14, 0), 1, 10, 0,
               1, issue_of(6, 1, 1), 1);
      add_step(disp_of(11, 15, 0, 15, 0), disp_of(12, 16, 0, 16, 0), 0, 0, 0,
               1, issue_of(6, 1, 1), 1);
      add_step(no_disp, no_disp, 0, 0, 0, 1, issue_of(6, 1, 1), 0);
      add_step(no_disp, no_disp, 0, 0, 1, 1, issue_of(6, 1, 1), 0);
      // Draining frees room again
      add_step(no_disp, no_disp, 0, 0, 1, 1, issue_of(5, 10, 11), 0);
      add_step(no_disp, no_disp, 0, 0, 1, 1, issue_of(7, 1, 1), 1);
      add_step(no_disp, no_disp, 1, 12, 1, 0, '0, 1);
      add_step(no_disp, no_disp, 1, 16, 1, 1, issue_of(8, 12, 12), 1);
      add_step(no_disp, no_disp, 1, 13, 1, 1, issue_of(12, 16, 16), 1);
      add_step(no_disp, no_disp, 1, 14, 1, 1, issue_of(9, 13, 13), 1);
      add_step(no_disp, no_disp, 1, 15, 1, 1, issue_of(10, 14, 14), 1);
      add_step(no_disp, no_disp, 0, 0, 1, 1, issue_of(11, 15, 15), 1);
      add_step(no_disp, no_disp, 0, 0, 1, 0, '0, 1);
   endtask

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------
   task automatic model_reset();
      for (int i = 0; i < n_ent; i++)
      begin
         m_valid[i] = 1'b0;
         m_r0[i]    = 1'b0;
         m_r1[i]    = 1'b0;
      end
      m_hold     = 1'b0;
      m_hold_idx = '0;
   endtask

   // Outputs seen before the coming edge
   task automatic model_expect();
      int               nfree;
      logic             found;
      logic [enc_w-1:0] pick;
      nfree = 0;
      found = 1'b0;
      pick  = '0;
      for (int i = 0; i < n_ent; i++)
      begin
         if (!m_valid[i])
            nfree++;
         if (!found && m_valid[i] && m_r0[i] && m_r1[i])
         begin
            found = 1'b1;
            pick  = enc_w'(i);
         end
      end
      m_exp_dr = (nfree >= 2);
      m_exp_iv = found;
      // Stalled item stays selected
      m_sel    = m_hold ? m_hold_idx : pick;
      m_exp_is = '{payload: m_pay[m_sel], src0_tag: m_t0[m_sel], src1_tag: m_t1[m_sel]};
   endtask

   task automatic model_load(input int k, input rs_dispatch_t d, input logic wv,
                             input rs_tag_t wt);
      m_valid[k] = 1'b1;
      m_pay[k]   = d.payload;
      m_t0[k]    = d.src0.tag;
      m_t1[k]    = d.src1.tag;
      // Same-cycle wakeup counts for the new entry
      m_r0[k]    = d.src0.ready | (wv && (d.src0.tag == wt));
      m_r1[k]    = d.src1.ready | (wv && (d.src1.tag == wt));
   endtask

   // State change at the edge
   task automatic model_update(input rs_dispatch_t d0, input rs_dispatch_t d1,
                               input logic wv, input rs_tag_t wt, input logic ir);
      int f0;
      int f1;
      f0 = -1;
      f1 = -1;
      for (int i = 0; i < n_ent; i++)
      begin
         if (!m_valid[i])
         begin
            if (f0 < 0)
               f0 = i;
            else if (f1 < 0)
               f1 = i;
         end
      end
      for (int i = 0; i < n_ent; i++)
      begin
         if (m_valid[i] && wv)
         begin
            if (m_t0[i] == wt)
               m_r0[i] = 1'b1;
            if (m_t1[i] == wt)
               m_r1[i] = 1'b1;
         end
      end
      if (m_exp_iv && ir)
         m_valid[m_sel] = 1'b0;
      if (m_exp_dr && d0.valid)
         model_load(f0, d0, wv, wt);
      if (m_exp_dr && d1.valid)
         model_load(f1, d1, wv, wt);
      m_hold = m_exp_iv & ~ir;
      if (m_hold)
         m_hold_idx = m_sel;
   endtask

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------
   task automatic check_model();
      assert (issue_valid === m_exp_iv)
      else
      begin
         err_model++;
         $display("[ERROR] %0t: issue_valid %b, model expects %b", $time, issue_valid, m_exp_iv);
      end
      assert (disp_ready === m_exp_dr)
      else
      begin
         err_model++;
         $display("[ERROR] %0t: disp_ready %b, model expects %b", $time, disp_ready, m_exp_dr);
      end
      assert (!m_exp_iv || issue === m_exp_is)
      else
      begin
         err_model++;
         $display("[ERROR] %0t: issue %h, model expects %h", $time, issue, m_exp_is);
      end
   endtask

   task automatic check_table(input int i);
      assert (issue_valid === steps[i].e_iv)
      else
      begin
         err_table++;
         $display("[ERROR] %0t: step %0d issue_valid %b, table expects %b",
                  $time, i, issue_valid, steps[i].e_iv);
      end
      assert (disp_ready === steps[i].e_dr)
      else
      begin
         err_table++;
         $display("[ERROR] %0t: step %0d disp_ready %b, table expects %b",
                  $time, i, disp_ready, steps[i].e_dr);
      end
      assert (!steps[i].e_iv || issue === steps[i].e_is)
      else
      begin
         err_table++;
         $display("[ERROR] %0t: step %0d issue %h, table expects %h",
                  $time, i, issue, steps[i].e_is);
      end
   endtask

   // Drive 1 ns after the edge, sample mid-cycle
   task automatic run_cycle(input rs_dispatch_t d0, input rs_dispatch_t d1, input logic wv,
                            input rs_tag_t wt, input logic ir);
      @(posedge nclk);
      #1;
      disp0       = d0;
      disp1       = d1;
      wake_valid  = wv;
      wake_tag    = wt;
      issue_ready = ir;
      #4;
      model_expect();
      check_model();
      model_update(d0, d1, wv, wt, ir);
   endtask

   task automatic soak_cycle();
      logic [31:0] ra;
      logic [31:0] rb;
      logic [31:0] rc;
      logic [31:0] rd;
      logic [31:0] rw;
      ra = next_rand();
      rb = next_rand();
      rc = next_rand();
      rd = next_rand();
      rw = next_rand();
      // issue_ready high three cycles in four
      run_cycle(rand_disp(ra, rb), rand_disp(rc, rd), rw[0], {2'b00, rw[3:1]}, |rw[5:4]);
   endtask

   // --------------------------------------------------
   // Main sequence and watchdog
   // --------------------------------------------------
   initial
   begin
      rst         = 1'b1;
      disp0       = '0;
      disp1       = '0;
      wake_valid  = 1'b0;
      wake_tag    = '0;
      issue_ready = 1'b0;
      build_table();
      model_reset();
      repeat (16) @(posedge nclk);
      #1 rst = 1'b0;
      for (int i = 0; i < steps.size(); i++)
      begin
         run_cycle(steps[i].d0, steps[i].d1, steps[i].wv, steps[i].wt, steps[i].ir);
         check_table(i);
      end
      for (int k = 0; k < soak_len; k++)
         soak_cycle();
      $display("Checks done: %0d table errors, %0d model errors", err_table, err_model);
      if (err_table + err_model == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

   initial
   begin
      #1;
      #((steps.size() + soak_len + 50) * 8);
      $display("Watchdog expired before the test sequence finished");
      $display("Some tests failed");
      $finish;
   end

endmodule

/* source/rs_station.sv */
/* Issue queue top level, joins entry control and payload storage to the pipe ports
   No registers of its own, so port timing is that of entry control */
`timescale 1ns/1ps

module rs_station #(
   parameter int num_entries = rs_pkg::rs_num_entries
) (
   input  logic                 nclk,
   input  logic                 rst,
   input  rs_pkg::rs_dispatch_t disp0,
   input  rs_pkg::rs_dispatch_t disp1,
   output logic                 disp_ready,
   input  logic                 wake_valid,
   input  rs_pkg::rs_tag_t      wake_tag,
   output logic                 issue_valid,
   output rs_pkg::rs_issue_t    issue,
   input  logic                 issue_ready
);
   import rs_pkg::*;

   localparam int enc_w = $clog2(num_entries);
   localparam int dat_w = rs_payload_w;

   // Array write and read control
   logic [enc_w-1:0]       w0_addr;
   logic                   w0_en;
   logic [enc_w-1:0]       w1_addr;
   logic                   w1_en;
   logic [num_entries-1:0] w_act;
   logic [enc_w-1:0]       r_addr;

   // Selected entry
   rs_tag_t                src0_tag;
   rs_tag_t                src1_tag;
   rs_payload_t            rd_payload;

   // --------------------------------------------------
   // Entry control
   // --------------------------------------------------
   rs_entry_ctrl #(
      .num_entries (num_entries),
      .enc_w       (enc_w)
   ) rs_entry_ctrl_inst (
      .nclk        (nclk),
      .rst         (rst),
      .disp0       (disp0),
      .disp1       (disp1),
      .disp_ready  (disp_ready),
      .wake_valid  (wake_valid),
      .wake_tag    (wake_tag),
      .issue_ready (issue_ready),
      .issue_valid (issue_valid),
      .src0_tag    (src0_tag),
      .src1_tag    (src1_tag),
      .w0_addr     (w0_addr),
      .w0_en       (w0_en),
      .w1_addr     (w1_addr),
      .w1_en       (w1_en),
      .w_act       (w_act),
      .r_addr      (r_addr)
   );

   // --------------------------------------------------
   // Payload storage
   // --------------------------------------------------

   // Dispatch payloads go straight to the two write ports
   rs_payload_array #(
      .num_entries (num_entries),
      .enc_w       (enc_w),
      .dat_w       (dat_w)
   ) rs_payload_array_inst (
      .nclk        (nclk),
      .rst         (rst),
      .w0_dat      (disp0.payload),
      .w0_addr     (w0_addr),
      .w0_en       (w0_en),
      .w1_dat      (disp1.payload),
      .w1_addr     (w1_addr),
      .w1_en       (w1_en),
      .w_act       (w_act),
      .r0_addr     (r_addr),
      .r0_dat      (rd_payload)
   );

   // Issue item, payload plus source tags for operand read
   assign issue = '{payload: rd_payload, src0_tag: src0_tag, src1_tag: src1_tag};

endmodule

/* source/rs_entry_ctrl.sv */
/* Entry control of the station: allocation, source wakeup and issue select
   Drives the write and read addresses of the payload array */
`timescale 1ns/1ps

module rs_entry_ctrl #(
   parameter int num_entries = 8,
   parameter int enc_w       = 3
) (
   input  logic                   nclk,
   input  logic                   rst,
   input  rs_pkg::rs_dispatch_t   disp0,
   input  rs_pkg::rs_dispatch_t   disp1,
   output logic                   disp_ready,
   input  logic                   wake_valid,
   input  rs_pkg::rs_tag_t        wake_tag,
   input  logic                   issue_ready,
   output logic                   issue_valid,
   output rs_pkg::rs_tag_t        src0_tag,
   output rs_pkg::rs_tag_t        src1_tag,
   output logic [enc_w-1:0]       w0_addr,
   output logic                   w0_en,
   output logic [enc_w-1:0]       w1_addr,
   output logic                   w1_en,
   output logic [num_entries-1:0] w_act,
   output logic [enc_w-1:0]       r_addr
);
   import rs_pkg::*;

   // Source ready at dispatch, with the same-cycle wakeup folded in
   function automatic logic src_ready_now(input rs_src_t src, input logic wv,
                                          input rs_tag_t wt);
      src_ready_now = src.ready | (wv & (src.tag == wt));
   endfunction

   // Entry state
   logic [num_entries-1:0] ent_valid;
   logic [num_entries-1:0] src0_rdy;
   logic [num_entries-1:0] src1_rdy;
   rs_tag_t                src0_tag_q [num_entries];
   rs_tag_t                src1_tag_q [num_entries];

   // Per-entry decode
   logic [num_entries-1:0] load0;
   logic [num_entries-1:0] load1;
   logic [num_entries-1:0] wake0_hit;
   logic [num_entries-1:0] wake1_hit;
   logic [num_entries-1:0] ent_ready;

   // Allocation and select
   logic [enc_w-1:0]       free0_idx;
   logic [enc_w-1:0]       free1_idx;
   logic                   free0_found;
   logic                   free1_found;
   logic [enc_w-1:0]       pick_idx;
   logic                   pick_found;
   logic [enc_w-1:0]       sel_idx;
   logic [enc_w-1:0]       hold_idx;
   logic                   hold_q;
   logic                   issue_fire;

   // Bypassed source ready of each dispatch lane
   logic                   d0_rdy0;
   logic                   d0_rdy1;
   logic                   d1_rdy0;
   logic                   d1_rdy1;

   // --------------------------------------------------
   // Allocation
   // --------------------------------------------------

   // Two lowest free entries, scanned upward
   always_comb
   begin
      free0_idx   = '0;
      free1_idx   = '0;
      free0_found = 1'b0;
      free1_found = 1'b0;
      for (int i = 0; i < num_entries; i++)
      begin
         if (!ent_valid[i])
         begin
            if (!free0_found)
            begin
               free0_idx   = enc_w'(i);
               free0_found = 1'b1;
            end
            else if (!free1_found)
            begin
               free1_idx   = enc_w'(i);
               free1_found = 1'b1;
            end
         end
      end
   end

   // Room for both lanes or none
   assign disp_ready = free1_found;
   assign w0_en      = disp0.valid & disp_ready;
   assign w0_addr    = free0_idx;
   assign w1_en      = disp1.valid & disp_ready;
   assign w1_addr    = free1_idx;

   assign d0_rdy0 = src_ready_now(disp0.src0, wake_valid, wake_tag);
   assign d0_rdy1 = src_ready_now(disp0.src1, wake_valid, wake_tag);
   assign d1_rdy0 = src_ready_now(disp1.src0, wake_valid, wake_tag);
   assign d1_rdy1 = src_ready_now(disp1.src1, wake_valid, wake_tag);

   for (genvar n = 0; n < num_entries; n++)
   begin : g_ent
      assign load0[n]     = w0_en & (w0_addr == enc_w'(n));
      assign load1[n]     = w1_en & (w1_addr == enc_w'(n));
      assign w_act[n]     = load0[n] | load1[n];
      // Wakeup tag compare per source
      assign wake0_hit[n] = wake_valid & (src0_tag_q[n] == wake_tag);
      assign wake1_hit[n] = wake_valid & (src1_tag_q[n] == wake_tag);
      assign ent_ready[n] = ent_valid[n] & src0_rdy[n] & src1_rdy[n];
   end

   // --------------------------------------------------
   // Issue select
   // --------------------------------------------------

   // Lowest ready index wins, so scan downward
   always_comb
   begin
      pick_idx   = '0;
      pick_found = 1'b0;
      for (int i = num_entries - 1; i >= 0; i--)
      begin
         if (ent_ready[i])
         begin
            pick_idx   = enc_w'(i);
            pick_found = 1'b1;
         end
      end
   end

   // A stalled pick stays put even if a lower entry wakes up
   assign sel_idx     = hold_q ? hold_idx : pick_idx;
   assign issue_valid = pick_found;
   assign issue_fire  = issue_valid & issue_ready;
   assign r_addr      = sel_idx;
   assign src0_tag    = src0_tag_q[sel_idx];
   assign src1_tag    = src1_tag_q[sel_idx];

   always_ff @(posedge nclk)
   begin
      if (rst)
         hold_q <= 1'b0;
      else
         hold_q <= issue_valid & ~issue_ready;
   end

   always_ff @(posedge nclk)
   begin
      if (issue_valid && !issue_ready)
         hold_idx <= sel_idx;
   end

   // --------------------------------------------------
   // Entry state update
   // --------------------------------------------------
   always_ff @(posedge nclk)
   begin
      if (rst)
      begin
         ent_valid <= '0;
         src0_rdy  <= '0;
         src1_rdy  <= '0;
      end
      else
      begin
         for (int i = 0; i < num_entries; i++)
         begin
            if (load0[i])
            begin
               ent_valid[i] <= 1'b1;
               src0_rdy[i]  <= d0_rdy0;
               src1_rdy[i]  <= d0_rdy1;
            end
            else if (load1[i])
            begin
               ent_valid[i] <= 1'b1;
               src0_rdy[i]  <= d1_rdy0;
               src1_rdy[i]  <= d1_rdy1;
            end
            else
            begin
               // Freed on the issue handshake
               if (issue_fire && (sel_idx == enc_w'(i)))
                  ent_valid[i] <= 1'b0;
               src0_rdy[i] <= src0_rdy[i] | (ent_valid[i] & wake0_hit[i]);
               src1_rdy[i] <= src1_rdy[i] | (ent_valid[i] & wake1_hit[i]);
            end
         end
      end
   end

   // Source tags, loaded on allocation only
   always_ff @(posedge nclk)
   begin
      for (int i = 0; i < num_entries; i++)
      begin
         if (load0[i])
         begin
            src0_tag_q[i] <= disp0.src0.tag;
            src1_tag_q[i] <= disp0.src1.tag;
         end
         else if (load1[i])
         begin
            src0_tag_q[i] <= disp1.src0.tag;
            src1_tag_q[i] <= disp1.src1.tag;
         end
      end
   end

endmodule

/* source/rs_payload_array.sv */
/* Payload storage of the station, two write ports and one AND-OR read port
   Write addresses and per-entry activity come from entry control */
`timescale 1ns/1ps

module rs_payload_array #(
   parameter int num_entries = 8,
   parameter int enc_w       = 3,
   parameter int dat_w       = 27
) (
   input  logic                   nclk,
   input  logic                   rst,
   input  logic [dat_w-1:0]       w0_dat,
   input  logic [enc_w-1:0]       w0_addr,
   input  logic                   w0_en,
   input  logic [dat_w-1:0]       w1_dat,
   input  logic [enc_w-1:0]       w1_addr,
   input  logic                   w1_en,
   input  logic [num_entries-1:0] w_act,
   input  logic [enc_w-1:0]       r0_addr,
   output logic [dat_w-1:0]       r0_dat
);

   // Per-entry write steering
   logic [num_entries-1:0] q_entry_load0;
   logic [num_entries-1:0] q_entry_load1;
   logic [num_entries-1:0] q_entry_hold;

   // One-hot read select
   logic [num_entries-1:0] q_entry_read;

   // Next and current entry contents
   logic [dat_w-1:0]       q_dat_d [num_entries];
   logic [dat_w-1:0]       q_dat_q [num_entries];

   // Gated read bits, grouped per data bit for the OR tree
   logic [num_entries-1:0] q_read_dat [dat_w];

   // --------------------------------------------------
   // Write select and storage
   // --------------------------------------------------
   for (genvar n = 0; n < num_entries; n++)
   begin : g_entry
      // Address decode per lane
      assign q_entry_load0[n] = w0_en & (w0_addr == enc_w'(n));
      assign q_entry_load1[n] = w1_en & (w1_addr == enc_w'(n));
      assign q_entry_hold[n]  = ~q_entry_load0[n] & ~q_entry_load1[n];

      // Lane 0, lane 1 or feedback
      assign q_dat_d[n] = (w0_dat     & {dat_w{q_entry_load0[n]}}) |
                          (w1_dat     & {dat_w{q_entry_load1[n]}}) |
                          (q_dat_q[n] & {dat_w{q_entry_hold[n]}});

      // Entry only clocks in new data when its activity bit is set
      always_ff @(posedge nclk)
      begin
         if (rst)
            q_dat_q[n] <= '0;
         else if (w_act[n])
            q_dat_q[n] <= q_dat_d[n];
      end

      // Read address to one-hot
      assign q_entry_read[n] = (r0_addr == enc_w'(n));

      // AND stage
      for (genvar b = 0; b < dat_w; b++)
      begin : g_and
         assign q_read_dat[b][n] = q_dat_q[n][b] & q_entry_read[n];
      end
   end

   // --------------------------------------------------
   // Read OR stage
   // --------------------------------------------------
   for (genvar b = 0; b < dat_w; b++)
   begin : g_or
      assign r0_dat[b] = |q_read_dat[b];
   end

endmodule

/* source/rs_pkg.sv */
/* Shared types and size constants for the issue queue reservation station
   Imported by the station RTL and its testbench */
package rs_pkg;

   // --------------------------------------------------
   // Sizes
   // --------------------------------------------------

   // Default entry count of one station
   localparam int rs_num_entries = 8;

   // Bits needed to index one entry
   localparam int rs_enc_w = $clog2(rs_num_entries);

   // --------------------------------------------------
   // Tags and payload
   // --------------------------------------------------

   // Physical register tag
   typedef logic [4:0] rs_tag_t;

   // Stored instruction payload, 27 bits
   typedef struct packed {
      logic [5:0]  opcode;
      rs_tag_t     dst;
      logic [15:0] imm;
   } rs_payload_t;

   // Payload width as seen by the storage array
   localparam int rs_payload_w = $bits(rs_payload_t);

   // --------------------------------------------------
   // Pipe port items
   // --------------------------------------------------

   // One source operand, tag plus ready flag
   typedef struct packed {
      rs_tag_t tag;
      logic    ready;
   } rs_src_t;

   // One dispatch lane, 40 bits
   typedef struct packed {
      logic        valid;
      rs_payload_t payload;
      rs_src_t     src0;
      rs_src_t     src1;
   } rs_dispatch_t;

   // Issued item toward the register file read stage, 37 bits
   // Source tags select the operand values there
   typedef struct packed {
      rs_payload_t payload;
      rs_tag_t     src0_tag;
      rs_tag_t     src1_tag;
   } rs_issue_t;

endpackage
